// ==== rtl/mem_pkg.sv ====
/*
 * memory dispatch sizes, index types, micro-op and exception records
 */
package mem_pkg;

    // dispatch and enqueue widths
    localparam int DISP_WIDTH   = 4;
    localparam int ENQ_WIDTH    = 2;
    localparam int COMMIT_WIDTH = 2;
    localparam int FU_NUM       = 4;

    // queue and register sizes
    localparam int LQ_SIZE   = 16;
    localparam int SQ_SIZE   = 16;
    localparam int ROB_IDX_W = 6;
    localparam int PREG_W    = 8;
    localparam int CAUSE_W   = 4;

    typedef logic [ROB_IDX_W-1:0]               rob_idx_t;
    typedef logic [$clog2(LQ_SIZE)-1:0]         lq_idx_t;
    typedef logic [$clog2(SQ_SIZE)-1:0]         sq_idx_t;
    typedef logic [PREG_W-1:0]                  preg_t;
    typedef logic [CAUSE_W-1:0]                 cause_t;
    typedef logic [$clog2(FU_NUM)-1:0]          fu_id_t;
    typedef logic [$clog2(COMMIT_WIDTH+1)-1:0]  commit_cnt_t;

    // counts of slots and queue occupancy
    typedef logic [$clog2(DISP_WIDTH+1)-1:0]    disp_cnt_t;
    typedef logic [$clog2(LQ_SIZE+1)-1:0]       lq_cnt_t;
    typedef logic [$clog2(SQ_SIZE+1)-1:0]       sq_cnt_t;

    // op as presented by dispatch
    typedef struct packed {
        rob_idx_t rob_idx;
        logic     is_store;
        preg_t    psrc;
        preg_t    pdst;
    } mem_op_t;

    // accepted op with its queue slots filled in
    typedef struct packed {
        rob_idx_t rob_idx;
        logic     is_store;
        preg_t    psrc;
        preg_t    pdst;
        lq_idx_t  lq_idx;
        sq_idx_t  sq_idx;
    } mem_uop_t;

    typedef struct packed {
        rob_idx_t rob_idx;
        cause_t   cause;
        fu_id_t   fu_id;
    } except_info_t;

endpackage

// ==== rtl/lsq_alloc_if.sv ====
/*
 * steering control to load/store queue allocator link
 */
`timescale 1ns/1ps

interface lsq_alloc_if import mem_pkg::*; ();

    logic [DISP_WIDTH-1:0] accept;
    logic [DISP_WIDTH-1:0] store_mask;
    logic                  can_enq;
    // per slot, valid only where accepted
    lq_idx_t               lq_idx[DISP_WIDTH];
    sq_idx_t               sq_idx[DISP_WIDTH];

    modport ctrl (
        output accept,
        output store_mask,
        input  can_enq,
        input  lq_idx,
        input  sq_idx
    );

    modport alloc (
        input  accept,
        input  store_mask,
        output can_enq,
        output lq_idx,
        output sq_idx
    );

endinterface

// ==== rtl/disp_steer.sv ====
/*
 * dispatch slot acceptance and load/store steering
 */
`timescale 1ns/1ps

module disp_steer import mem_pkg::*; (
    input  logic [DISP_WIDTH-1:0] i_disp_req,
    input  mem_op_t               i_disp_op[DISP_WIDTH],
    input  logic                  i_ld_iq_rdy,
    input  logic                  i_st_iq_rdy,
    output logic [DISP_WIDTH-1:0] o_disp_rdy,
    output logic [DISP_WIDTH-1:0] o_ld_sel,
    output logic [DISP_WIDTH-1:0] o_st_sel,
    lsq_alloc_if.ctrl             alloc
);

    logic [DISP_WIDTH-1:0] accept;

    always_comb begin
        disp_cnt_t ld_cnt;
        disp_cnt_t st_cnt;
        logic      chain;
        logic      is_st;
        logic      kind_ok;
        logic      take;

        ld_cnt   = '0;
        st_cnt   = '0;
        chain    = 1'b1;
        accept   = '0;
        o_ld_sel = '0;
        o_st_sel = '0;
        for (int i = 0; i < DISP_WIDTH; i++) begin
            is_st = i_disp_op[i].is_store;
            // queue ready and lane budget of this op's kind
            if (is_st) begin
                kind_ok = i_st_iq_rdy && (st_cnt < disp_cnt_t'(ENQ_WIDTH));
            end else begin
                kind_ok = i_ld_iq_rdy && (ld_cnt < disp_cnt_t'(ENQ_WIDTH));
            end
            take = i_disp_req[i] && alloc.can_enq && kind_ok && chain;

            accept[i]   = take;
            o_ld_sel[i] = take && !is_st;
            o_st_sel[i] = take && is_st;
            if (take && is_st) begin
                st_cnt = st_cnt + disp_cnt_t'(1);
            end
            if (take && !is_st) begin
                ld_cnt = ld_cnt + disp_cnt_t'(1);
            end
            // a refused slot blocks every younger slot
            chain = take;
        end
    end

    always_comb begin
        for (int i = 0; i < DISP_WIDTH; i++) begin
            alloc.store_mask[i] = i_disp_op[i].is_store;
        end
    end

    assign alloc.accept = accept;
    assign o_disp_rdy   = accept;

endmodule

// ==== rtl/lsq_alloc.sv ====
/*
 * virtual load/store queue: tails, occupancy and index assignment
 */
`timescale 1ns/1ps

module lsq_alloc import mem_pkg::*; (
    input  logic        clk,
    input  logic        i_arst_n,
    input  commit_cnt_t i_committed_loads,
    input  commit_cnt_t i_committed_stores,
    lsq_alloc_if.alloc  ctrl
);

    lq_idx_t   ld_tail;
    sq_idx_t   st_tail;
    lq_cnt_t   ld_occ;
    sq_cnt_t   st_occ;
    disp_cnt_t ld_acc;
    disp_cnt_t st_acc;

    // prefix counts give each accepted slot its index
    always_comb begin
        disp_cnt_t ld_run;
        disp_cnt_t st_run;

        ld_run = '0;
        st_run = '0;
        for (int i = 0; i < DISP_WIDTH; i++) begin
            ctrl.lq_idx[i] = ld_tail + lq_idx_t'(ld_run);
            ctrl.sq_idx[i] = st_tail + sq_idx_t'(st_run);
            if (ctrl.accept[i] && ctrl.store_mask[i]) begin
                st_run = st_run + disp_cnt_t'(1);
            end
            if (ctrl.accept[i] && !ctrl.store_mask[i]) begin
                ld_run = ld_run + disp_cnt_t'(1);
            end
        end
        ld_acc = ld_run;
        st_acc = st_run;
    end

    // room for a full dispatch group in both queues
    assign ctrl.can_enq = ((lq_cnt_t'(LQ_SIZE) - ld_occ) >= lq_cnt_t'(DISP_WIDTH)) &&
                          ((sq_cnt_t'(SQ_SIZE) - st_occ) >= sq_cnt_t'(DISP_WIDTH));

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            ld_tail <= '0;
            st_tail <= '0;
            ld_occ  <= '0;
            st_occ  <= '0;
        end else begin
            // tails wrap modulo queue size
            ld_tail <= ld_tail + lq_idx_t'(ld_acc);
            st_tail <= st_tail + sq_idx_t'(st_acc);
            ld_occ  <= ld_occ + lq_cnt_t'(ld_acc) - lq_cnt_t'(i_committed_loads);
            st_occ  <= st_occ + sq_cnt_t'(st_acc) - sq_cnt_t'(i_committed_stores);
        end
    end

endmodule

// ==== rtl/slot_compact.sv ====
/*
 * in-order compaction of selected dispatch slots into enqueue lanes
 */
`timescale 1ns/1ps

module slot_compact import mem_pkg::*; #(
    parameter type dtype = mem_uop_t
) (
    input  logic [DISP_WIDTH-1:0] i_sel,
    input  dtype                  i_data[DISP_WIDTH],
    output logic [ENQ_WIDTH-1:0]  o_vld,
    output dtype                  o_data[ENQ_WIDTH]
);

    always_comb begin
        int lane;

        lane  = 0;
        o_vld = '0;
        for (int k = 0; k < ENQ_WIDTH; k++) begin
            o_data[k] = '0;
        end
        // oldest selected slot lands in lane 0
        for (int i = 0; i < DISP_WIDTH; i++) begin
            if (i_sel[i] && lane < ENQ_WIDTH) begin
                o_vld[lane]  = 1'b1;
                o_data[lane] = i_data[i];
                lane         = lane + 1;
            end
        end
    end

endmodule

// ==== rtl/except_arb.sv ====
/*
 * oldest exception select and its output register
 */
`timescale 1ns/1ps

module except_arb import mem_pkg::*; (
    input  logic             clk,
    input  logic             i_arst_n,
    input  logic             i_squash,
    input  logic [FU_NUM-1:0] i_vld,
    input  except_info_t     i_info[FU_NUM],
    output logic             o_vld,
    output except_info_t     o_info
);

    logic     best_vld;
    fu_id_t   best_fu;
    rob_idx_t best_rob;

    // strict compare keeps the lower fu on equal rob index
    always_comb begin
        best_vld = 1'b0;
        best_fu  = '0;
        best_rob = '0;
        for (int i = 0; i < FU_NUM; i++) begin
            if (i_vld[i] && (!best_vld || i_info[i].rob_idx < best_rob)) begin
                best_vld = 1'b1;
                best_fu  = fu_id_t'(i);
                best_rob = i_info[i].rob_idx;
            end
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_vld <= 1'b0;
        end else begin
            // squash wins over same-cycle reports
            o_vld <= best_vld && !i_squash;
        end
    end

    always_ff @(posedge clk) begin
        if (best_vld) begin
            o_info <= i_info[best_fu];
        end
    end

endmodule

// ==== rtl/mem_dispatch_top.sv ====
/*
 * memory dispatch front end: steering, queue allocation,
 * enqueue compaction and exception select
 */
`timescale 1ns/1ps

module mem_dispatch_top import mem_pkg::*; (
    input  logic                  clk,
    input  logic                  i_arst_n,
    input  logic                  i_squash,

    // dispatch side
    input  logic [DISP_WIDTH-1:0] i_disp_req,
    input  mem_op_t               i_disp_op[DISP_WIDTH],
    output logic [DISP_WIDTH-1:0] o_disp_rdy,

    // issue queue enqueue
    input  logic                  i_ld_iq_rdy,
    input  logic                  i_st_iq_rdy,
    output logic [ENQ_WIDTH-1:0]  o_ld_enq_vld,
    output mem_uop_t              o_ld_uop[ENQ_WIDTH],
    output logic [ENQ_WIDTH-1:0]  o_st_enq_vld,
    output mem_uop_t              o_st_uop[ENQ_WIDTH],

    // commit
    input  commit_cnt_t           i_committed_loads,
    input  commit_cnt_t           i_committed_stores,

    // exceptions from the functional units
    input  logic [FU_NUM-1:0]     i_fu_except_vld,
    input  except_info_t          i_fu_except_info[FU_NUM],
    output logic                  o_except_vld,
    output except_info_t          o_except_info
);

    logic [DISP_WIDTH-1:0] ld_sel;
    logic [DISP_WIDTH-1:0] st_sel;
    mem_uop_t              disp_uop[DISP_WIDTH];

    lsq_alloc_if alloc_if ();

    disp_steer u_disp_steer (
        .i_disp_req  (i_disp_req),
        .i_disp_op   (i_disp_op),
        .i_ld_iq_rdy (i_ld_iq_rdy),
        .i_st_iq_rdy (i_st_iq_rdy),
        .o_disp_rdy  (o_disp_rdy),
        .o_ld_sel    (ld_sel),
        .o_st_sel    (st_sel),
        .alloc       (alloc_if)
    );

    lsq_alloc u_lsq_alloc (
        .clk                (clk),
        .i_arst_n           (i_arst_n),
        .i_committed_loads  (i_committed_loads),
        .i_committed_stores (i_committed_stores),
        .ctrl               (alloc_if)
    );

    // attach queue slots to each dispatched op
    always_comb begin
        for (int i = 0; i < DISP_WIDTH; i++) begin
            disp_uop[i] = '{rob_idx:  i_disp_op[i].rob_idx,
                            is_store: i_disp_op[i].is_store,
                            psrc:     i_disp_op[i].psrc,
                            pdst:     i_disp_op[i].pdst,
                            lq_idx:   alloc_if.lq_idx[i],
                            sq_idx:   alloc_if.sq_idx[i]};
        end
    end

    slot_compact #(.dtype(mem_uop_t)) u_ld_compact (
        .i_sel  (ld_sel),
        .i_data (disp_uop),
        .o_vld  (o_ld_enq_vld),
        .o_data (o_ld_uop)
    );

    slot_compact #(.dtype(mem_uop_t)) u_st_compact (
        .i_sel  (st_sel),
        .i_data (disp_uop),
        .o_vld  (o_st_enq_vld),
        .o_data (o_st_uop)
    );

    except_arb u_except_arb (
        .clk      (clk),
        .i_arst_n (i_arst_n),
        .i_squash (i_squash),
        .i_vld    (i_fu_except_vld),
        .i_info   (i_fu_except_info),
        .o_vld    (o_except_vld),
        .o_info   (o_except_info)
    );

endmodule

// ==== tests/tb_mem_dispatch.sv ====
/*
 * directed testbench for the memory dispatch front end with
 * reference model, compare tasks, tests and watchdog
 */
`timescale 1ns/1ps

module tb_mem_dispatch import mem_pkg::*; ();

    localparam int NUM_TESTS       = 5;
    localparam int WATCHDOG_CYCLES = NUM_TESTS * 40 + 20;

    logic clk, arst_n, squash, ld_iq_rdy, st_iq_rdy, except_vld;
    logic [DISP_WIDTH-1:0] disp_req, disp_rdy;
    logic [ENQ_WIDTH-1:0]  ld_enq_vld, st_enq_vld;
    logic [FU_NUM-1:0]     fu_except_vld;
    mem_op_t               disp_op[DISP_WIDTH];
    mem_uop_t              ld_uop[ENQ_WIDTH], st_uop[ENQ_WIDTH];
    commit_cnt_t           committed_loads, committed_stores;
    except_info_t          fu_except_info[FU_NUM], except_info;

    // stimulus for the next dispatch cycle
    logic [DISP_WIDTH-1:0] stim_req;
    mem_op_t               stim_op[DISP_WIDTH];
    logic                  stim_ld_rdy, stim_st_rdy;
    commit_cnt_t           stim_cl, stim_cs;

    // reference model state and expected outputs
    lq_idx_t               m_ld_tail;
    sq_idx_t               m_st_tail;
    int                    m_ld_occ, m_st_occ, m_ld_acc, m_st_acc;
    logic [DISP_WIDTH-1:0] exp_rdy;
    logic [ENQ_WIDTH-1:0]  exp_ld_vld, exp_st_vld;
    mem_uop_t              exp_ld_uop[ENQ_WIDTH], exp_st_uop[ENQ_WIDTH];

    int          err_cnt;

    mem_dispatch_top UUT (
        .clk(clk), .i_arst_n(arst_n), .i_squash(squash),
        .i_disp_req(disp_req), .i_disp_op(disp_op), .o_disp_rdy(disp_rdy),
        .i_ld_iq_rdy(ld_iq_rdy), .i_st_iq_rdy(st_iq_rdy),
        .o_ld_enq_vld(ld_enq_vld), .o_ld_uop(ld_uop),
        .o_st_enq_vld(st_enq_vld), .o_st_uop(st_uop),
        .i_committed_loads(committed_loads), .i_committed_stores(committed_stores),
        .i_fu_except_vld(fu_except_vld), .i_fu_except_info(fu_except_info),
        .o_except_vld(except_vld), .o_except_info(except_info)
    );

    always #50 clk = ~clk;

    task automatic compare_mask(input string name, input logic [DISP_WIDTH-1:0] exp,
                                input logic [DISP_WIDTH-1:0] act);
        if (exp !== act) begin
            $display("** Error [%s] expected %b, actual %b", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic compare_uop(input string name, input mem_uop_t exp, input mem_uop_t act);
        if (exp !== act) begin
            $display("** Error [%s] expected %h, actual %h", name, exp, act);
            err_cnt++;
        end
    endtask

    task automatic compare_except(input string name, input except_info_t exp,
                                  input except_info_t act);
        if (exp !== act) begin
            $display("** Error [%s] expected %h, actual %h", name, exp, act);
            err_cnt++;
        end
    endtask

    function automatic logic [DISP_WIDTH-1:0] widen(input logic [ENQ_WIDTH-1:0] v);
        return {{(DISP_WIDTH-ENQ_WIDTH){1'b0}}, v};
    endfunction

    function automatic logic model_room();
        return (LQ_SIZE - m_ld_occ >= DISP_WIDTH) && (SQ_SIZE - m_st_occ >= DISP_WIDTH);
    endfunction

    task automatic make_op(input int slot, input logic is_store);
        stim_op[slot] = '{rob_idx: rob_idx_t'($urandom), is_store: is_store,
                          psrc: preg_t'($urandom), pdst: preg_t'($urandom)};
    endtask

    task automatic clear_stim();
        stim_req    = '0;
        stim_ld_rdy = 1'b1;
        stim_st_rdy = 1'b1;
        stim_cl     = '0;
        stim_cs     = '0;
        for (int i = 0; i < DISP_WIDTH; i++) begin
            stim_op[i] = '0;
        end
    endtask

    // in-order acceptance, per-kind lane limit and index assignment
    task automatic model_dispatch();
        logic open;
        logic kind_ok;

        open       = 1'b1;
        m_ld_acc   = 0;
        m_st_acc   = 0;
        exp_rdy    = '0;
        exp_ld_vld = '0;
        exp_st_vld = '0;
        for (int i = 0; i < DISP_WIDTH; i++) begin
            kind_ok = stim_op[i].is_store ? (stim_st_rdy && m_st_acc < ENQ_WIDTH)
                                          : (stim_ld_rdy && m_ld_acc < ENQ_WIDTH);
            if (!(open && stim_req[i] && model_room() && kind_ok)) begin
                open = 1'b0;
            end else if (stim_op[i].is_store) begin
                exp_rdy[i]           = 1'b1;
                exp_st_vld[m_st_acc] = 1'b1;
                exp_st_uop[m_st_acc] = {stim_op[i], m_ld_tail + lq_idx_t'(m_ld_acc),
                                        m_st_tail + sq_idx_t'(m_st_acc)};
                m_st_acc++;
            end else begin
                exp_rdy[i]           = 1'b1;
                exp_ld_vld[m_ld_acc] = 1'b1;
                exp_ld_uop[m_ld_acc] = {stim_op[i], m_ld_tail + lq_idx_t'(m_ld_acc),
                                        m_st_tail + sq_idx_t'(m_st_acc)};
                m_ld_acc++;
            end
        end
    endtask

    // one dispatch cycle drives, checks at the falling edge and advances the model
    task automatic dispatch_cycle(input string name);
        @(posedge clk);
        disp_req         <= stim_req;
        ld_iq_rdy        <= stim_ld_rdy;
        st_iq_rdy        <= stim_st_rdy;
        committed_loads  <= stim_cl;
        committed_stores <= stim_cs;
        for (int i = 0; i < DISP_WIDTH; i++) begin
            disp_op[i] <= stim_op[i];
        end
        model_dispatch();
        @(negedge clk);
        compare_mask({name, " rdy"}, exp_rdy, disp_rdy);
        compare_mask({name, " ld_vld"}, widen(exp_ld_vld), widen(ld_enq_vld));
        compare_mask({name, " st_vld"}, widen(exp_st_vld), widen(st_enq_vld));
        for (int k = 0; k < ENQ_WIDTH; k++) begin
            if (exp_ld_vld[k]) compare_uop({name, " ld_uop"}, exp_ld_uop[k], ld_uop[k]);
            if (exp_st_vld[k]) compare_uop({name, " st_uop"}, exp_st_uop[k], st_uop[k]);
        end
        m_ld_tail = m_ld_tail + lq_idx_t'(m_ld_acc);
        m_st_tail = m_st_tail + sq_idx_t'(m_st_acc);
        m_ld_occ  = m_ld_occ + m_ld_acc - int'(stim_cl);
        m_st_occ  = m_st_occ + m_st_acc - int'(stim_cs);
    endtask

    task automatic idle_cycle(input string name);
        clear_stim();
        dispatch_cycle({name, " idle"});
    endtask

    task automatic test_reset();
        compare_mask("test_reset except_vld", '0, {{(DISP_WIDTH-1){1'b0}}, except_vld});
        clear_stim();
        stim_req = 4'b1111;
        make_op(0, 1'b0);
        make_op(1, 1'b1);
        make_op(2, 1'b0);
        make_op(3, 1'b1);
        dispatch_cycle("test_reset");
        compare_mask("test_reset full accept", 4'b1111, disp_rdy);
        idle_cycle("test_reset");
    endtask

    task automatic test_steer_order();
        clear_stim();
        stim_req = 4'b1111;
        for (int i = 0; i < 3; i++) make_op(i, 1'b0);
        make_op(3, 1'b1);
        dispatch_cycle("test_steer_order");
        compare_mask("test_steer_order two loads", 4'b0011, disp_rdy);
        idle_cycle("test_steer_order");
    endtask

    task automatic test_backpressure();
        clear_stim();
        stim_req    = 4'b0111;
        stim_st_rdy = 1'b0;
        make_op(0, 1'b0);
        make_op(1, 1'b1);
        make_op(2, 1'b0);
        dispatch_cycle("test_backpressure st_rdy low");
        compare_mask("test_backpressure st_rdy low", 4'b0001, disp_rdy);
        clear_stim();
        stim_req    = 4'b1111;
        stim_ld_rdy = 1'b0;
        make_op(0, 1'b1);
        make_op(1, 1'b0);
        make_op(2, 1'b1);
        make_op(3, 1'b1);
        dispatch_cycle("test_backpressure ld_rdy low");
        compare_mask("test_backpressure ld_rdy low", 4'b0001, disp_rdy);
        idle_cycle("test_backpressure");
    endtask

    task automatic test_lsq_capacity();
        lq_idx_t prev_idx;
        logic    wrapped;

        wrapped  = 1'b0;
        prev_idx = '0;
        clear_stim();
        stim_req = 4'b1111;
        for (int n = 0; n < 16 && model_room(); n++) begin
            for (int i = 0; i < DISP_WIDTH; i++) make_op(i, 1'b0);
            dispatch_cycle("test_lsq_capacity fill");
        end
        if (m_ld_occ <= LQ_SIZE - DISP_WIDTH) begin
            $display("test_lsq_capacity: load queue never filled past the dispatch margin");
            err_cnt++;
        end
        dispatch_cycle("test_lsq_capacity full");
        compare_mask("test_lsq_capacity full", '0, disp_rdy);
        // drain a little then keep dispatching with steady commits
        stim_req = '0;
        stim_cl  = commit_cnt_t'(COMMIT_WIDTH);
        repeat (2) dispatch_cycle("test_lsq_capacity commit");
        stim_req = 4'b1111;
        for (int n = 0; n < 6; n++) begin
            for (int i = 0; i < DISP_WIDTH; i++) make_op(i, 1'b0);
            dispatch_cycle("test_lsq_capacity refill");
            compare_mask("test_lsq_capacity refill", 4'b0011, disp_rdy);
            // lane 0 index drops once the load queue index wraps
            if (n > 0 && ld_uop[0].lq_idx < prev_idx) wrapped = 1'b1;
            prev_idx = ld_uop[0].lq_idx;
        end
        if (!wrapped) begin
            $display("test_lsq_capacity: load queue index never wrapped around");
            err_cnt++;
        end
        idle_cycle("test_lsq_capacity");
    endtask

    task automatic test_except_oldest();
        except_info_t best;
        logic         found;
        logic [FU_NUM-1:0] v;

        for (int r = 0; r < 16; r++) begin
            v     = (r == 0) ? '0 : FU_NUM'($urandom);
            found = 1'b0;
            best  = '0;
            @(posedge clk);
            fu_except_vld <= v;
            // narrow rob range so ties between units show up
            for (int f = 0; f < FU_NUM; f++) begin
                fu_except_info[f] <= '{rob_idx: rob_idx_t'($urandom_range(7)),
                                       cause: cause_t'($urandom), fu_id: fu_id_t'(f)};
            end
            @(negedge clk);
            for (int f = FU_NUM - 1; f >= 0; f--) begin
                if (v[f] && (!found || fu_except_info[f].rob_idx <= best.rob_idx)) begin
                    best  = fu_except_info[f];
                    found = 1'b1;
                end
            end
            @(posedge clk);
            fu_except_vld <= '0;
            @(negedge clk);
            compare_mask("test_except_oldest vld", {{(DISP_WIDTH-1){1'b0}}, found},
                         {{(DISP_WIDTH-1){1'b0}}, except_vld});
            if (found) compare_except("test_except_oldest info", best, except_info);
        end
        @(posedge clk);
        fu_except_vld <= '1;
        squash        <= 1'b1;
        @(posedge clk);
        fu_except_vld <= '0;
        squash        <= 1'b0;
        @(negedge clk);
        compare_mask("test_except_oldest squash", '0, {{(DISP_WIDTH-1){1'b0}}, except_vld});
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired before the tests completed");
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        void'($urandom(60398));
        err_cnt  = 0;
        clk      = 1'b0;
        arst_n   = 1'b0;
        squash   = 1'b0;
        disp_req = '0;
        ld_iq_rdy = 1'b1;
        st_iq_rdy = 1'b1;
        committed_loads  = '0;
        committed_stores = '0;
        fu_except_vld    = '0;
        for (int i = 0; i < DISP_WIDTH; i++) disp_op[i] = '0;
        for (int f = 0; f < FU_NUM; f++) fu_except_info[f] = '0;
        m_ld_tail = '0;
        m_st_tail = '0;
        m_ld_occ  = 0;
        m_st_occ  = 0;
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        test_reset();
        test_steer_order();
        test_backpressure();
        test_lsq_capacity();
        test_except_oldest();
        $display("tests done, %0d errors", err_cnt);
        if (err_cnt == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
rtl/mem_pkg.sv
rtl/lsq_alloc_if.sv
rtl/disp_steer.sv
rtl/lsq_alloc.sv
rtl/slot_compact.sv
rtl/except_arb.sv
rtl/mem_dispatch_top.sv
tests/tb_mem_dispatch.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the memory dispatch testbench with Verilator
verilator --binary -f sim.f --top-module tb_mem_dispatch -o Vtb_mem_dispatch && \
    ./obj_dir/Vtb_mem_dispatch | tee /dev/stderr | grep -q "NO ERRORS" && \
    echo "simulation passed" || { echo "simulation failed"; exit 1; }
